/* compile.f */
+incdir+hdl
hdl/nfu_types_pkg.sv
hdl/nfu_ctrl_pkg.sv
hdl/nfu_input_stage.sv
hdl/nfu_select_buffer.sv
hdl/nfu_accum_tree.sv
hdl/nfu2_top.sv
verif/nfu2_chk.sv
verif/nfu2_tb.sv

/* verif/nfu2_tb.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu2_tb
    import nfu_types_pkg::*;
    import nfu_ctrl_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int RESET_VECTORS  = 3;
    localparam int LOAD_VECTORS   = 4;
    localparam int ACCUM_VECTORS  = 6;
    localparam int TERM_VECTORS   = 6;
    localparam int RANDOM_VECTORS = 200;
    localparam int TOTAL_VECTORS  = RESET_VECTORS + LOAD_VECTORS + ACCUM_VECTORS
                                  + TERM_VECTORS + RANDOM_VECTORS;
    localparam int RUN_LIMIT_NS   = (TOTAL_VECTORS + 20) * CLK_PERIOD;

    // Model of every lane's term buffer
    typedef nfu_word_t [`NFU_TN-1:0][`NFU_DEPTH-1:0] term_buf_t;

    // One expected result waiting for its output cycle
    typedef struct {
        nfu_lanes_t lanes;
        nfu_tag_t   tag;
        int         due;
        string      test;
        bit         last;
    } expect_t;

    logic          clk;
    logic          i_rst_n;
    nfu_products_t i_products;
    nfu_lanes_t    i_partial_sum;
    nfu_ctrl_t     i_ctrl;
    nfu_lanes_t    o_output;
    nfu_tag_t      o_tag;

    integer     seed;
    int         neg_cnt = 0;
    expect_t    exp_q[$];
    string      cur_test;
    term_buf_t  model_buf;
    nfu_lanes_t model_acc;

    int check_total  = 0;
    int err_total    = 0;
    int test_checks  = 0;
    int test_errs    = 0;
    int tests_done   = 0;
    int tests_failed = 0;

    nfu2_top dut_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_products    (i_products),
        .i_partial_sum (i_partial_sum),
        .i_ctrl        (i_ctrl),
        .o_output      (o_output),
        .o_tag         (o_tag)
    );

    bind nfu2_top nfu2_chk chk_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_ctrl   (i_ctrl),
        .o_output (o_output),
        .o_tag    (o_tag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Falling edge count, the time base for expected results
    always @(negedge clk) begin
        neg_cnt <= neg_cnt + 1;
    end

    // Expected lanes for one item, then the buffer and accumulator updates
    function automatic nfu_lanes_t ref_step(
        input  nfu_products_t p,
        input  nfu_lanes_t    psum,
        input  nfu_ctrl_t     c,
        inout  term_buf_t     tbuf,
        inout  nfu_lanes_t    acc,
        output nfu_tag_t      tag
    );
        nfu_lanes_t result;
        nfu_word_t  sum;
        int         r;
        int         col;
        for (int l = 0; l < `NFU_TN; l++) begin
            sum = c.load ? psum.lane[l] : acc.lane[l];
            sum = sum + tbuf[l][c.rd_addr[l]];
            for (int k = 0; k < `NFU_TN; k++) begin
                sum = sum + p.row[l][k];
            end
            result.lane[l] = sum;
        end
        // Writes come after the read, so a same entry read sees the old word
        for (int l = 0; l < `NFU_TN; l++) begin
            if (c.wr_en[l]) begin
                r   = c.sel[l] / `NFU_TN;
                col = c.sel[l] % `NFU_TN;
                tbuf[l][c.wr_addr[l]] = p.row[r][col];
            end
        end
        acc = result;
        tag = c.tag;
        return result;
    endfunction

    task automatic compare_value(
        input string                  test_name,
        input string                  what,
        input logic [`NFU_WIDTH-1:0]  expected,
        input logic [`NFU_WIDTH-1:0]  actual
    );
        check_total++;
        test_checks++;
        if (actual !== expected) begin
            err_total++;
            test_errs++;
            $display("[ERROR] %s %s: expected 0x%h, actual 0x%h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_test(input string test_name);
        tests_done++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d checks, %0d errors, %s", test_name, test_checks,
                 test_errs, (test_errs == 0) ? "ok" : "FAILED");
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic random_products(output nfu_products_t p);
        for (int r = 0; r < `NFU_TN; r++) begin
            for (int k = 0; k < `NFU_TN; k++) begin
                p.row[r][k] = $random(seed);
            end
        end
    endtask

    task automatic random_lanes(output nfu_lanes_t v);
        for (int l = 0; l < `NFU_TN; l++) begin
            v.lane[l] = $random(seed);
        end
    endtask

    // Drives one item on the falling edge and queues its expected result
    task automatic apply_vector(
        input nfu_products_t p,
        input nfu_lanes_t    psum,
        input nfu_ctrl_t     c,
        input bit            last
    );
        expect_t e;
        @(negedge clk);
        i_products    = p;
        i_partial_sum = psum;
        i_ctrl        = c;
        e.lanes = ref_step(p, psum, c, model_buf, model_acc, e.tag);
        e.due   = neg_cnt + 2;
        e.test  = cur_test;
        e.last  = last;
        exp_q.push_back(e);
    endtask

    task automatic run_reset();
        nfu_products_t p;
        nfu_lanes_t    ps;
        nfu_ctrl_t     c;
        cur_test = "reset";
        p  = '0;
        ps = '0;
        c  = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            for (int l = 0; l < `NFU_TN; l++) begin
                compare_value(cur_test, $sformatf("lane %0d in reset", l), '0,
                              o_output.lane[l]);
            end
            compare_value(cur_test, "tag in reset", '0, o_tag);
        end
        i_rst_n = 1'b1;
        // Idle items right after reset must still give zero
        for (int i = 0; i < RESET_VECTORS; i++) begin
            apply_vector(p, ps, c, i == RESET_VECTORS - 1);
        end
    endtask

    task automatic run_load();
        nfu_products_t p;
        nfu_lanes_t    ps;
        nfu_ctrl_t     c;
        cur_test = "load_row_sum";
        for (int i = 0; i < LOAD_VECTORS; i++) begin
            random_products(p);
            random_lanes(ps);
            c         = '0;
            c.load    = 1'b1;
            c.rd_addr = $random(seed);
            c.tag     = $random(seed);
            apply_vector(p, ps, c, i == LOAD_VECTORS - 1);
        end
    endtask

    task automatic run_accum();
        nfu_products_t p;
        nfu_lanes_t    ps;
        nfu_ctrl_t     c;
        cur_test = "accumulate";
        for (int i = 0; i < ACCUM_VECTORS; i++) begin
            random_products(p);
            random_lanes(ps);
            c      = '0;
            c.load = (i == 0);
            c.tag  = $random(seed);
            apply_vector(p, ps, c, i == ACCUM_VECTORS - 1);
        end
    endtask

    task automatic run_term();
        nfu_products_t p;
        nfu_lanes_t    ps;
        nfu_ctrl_t     c;
        cur_test = "selected_term";
        ps = '0;
        c  = '0;
        c.load = 1'b1;
        // Each lane stores the anti-diagonal product of its row in entry 2
        random_products(p);
        for (int l = 0; l < `NFU_TN; l++) begin
            c.sel[l]     = l * `NFU_TN + (`NFU_TN - 1 - l);
            c.wr_addr[l] = 2;
            c.rd_addr[l] = 0;
            c.wr_en[l]   = 1'b1;
        end
        c.tag = 1;
        apply_vector(p, ps, c, 1'b0);
        // Entry 2 read back adds the stored product
        random_products(p);
        c.wr_en = '0;
        for (int l = 0; l < `NFU_TN; l++) begin
            c.rd_addr[l] = 2;
        end
        c.tag = 2;
        apply_vector(p, ps, c, 1'b0);
        // Read and write of entry 2 together, old word joins the sum
        random_products(p);
        for (int l = 0; l < `NFU_TN; l++) begin
            c.sel[l]   = (l * 5 + 3) % NFU_GRID;
            c.wr_en[l] = 1'b1;
        end
        c.tag = 3;
        apply_vector(p, ps, c, 1'b0);
        random_products(p);
        c.wr_en = '0;
        c.tag   = 0;
        apply_vector(p, ps, c, 1'b0);
        // Only even lanes write entry 1
        random_products(p);
        for (int l = 0; l < `NFU_TN; l++) begin
            c.sel[l]     = $random(seed);
            c.wr_addr[l] = 1;
            c.rd_addr[l] = 1;
            c.wr_en[l]   = (l % 2 == 0);
        end
        apply_vector(p, ps, c, 1'b0);
        random_products(p);
        c.wr_en = '0;
        c.tag   = 1;
        apply_vector(p, ps, c, 1'b1);
    endtask

    task automatic run_random();
        nfu_products_t p;
        nfu_lanes_t    ps;
        nfu_ctrl_t     c;
        cur_test = "random_stream";
        for (int i = 0; i < RANDOM_VECTORS; i++) begin
            random_products(p);
            random_lanes(ps);
            c.sel     = $random(seed);
            c.wr_addr = $random(seed);
            c.rd_addr = $random(seed);
            c.wr_en   = $random(seed);
            c.load    = (($random(seed) & 3) == 0);
            c.tag     = $random(seed);
            apply_vector(p, ps, c, i == RANDOM_VECTORS - 1);
        end
    endtask

    // Compares each queued result on the falling edge it is due
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            while (exp_q.size() > 0 && exp_q[0].due == neg_cnt) begin
                e = exp_q.pop_front();
                for (int l = 0; l < `NFU_TN; l++) begin
                    compare_value(e.test, $sformatf("lane %0d", l), e.lanes.lane[l],
                                  o_output.lane[l]);
                end
                compare_value(e.test, "tag", e.tag, o_tag);
                if (e.last) begin
                    report_test(e.test);
                end
            end
        end
    end

    initial begin
        #(RUN_LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", RUN_LIMIT_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed          = 17347;
        i_rst_n       = 1'b0;
        i_products    = '0;
        i_partial_sum = '0;
        i_ctrl        = '0;
        model_buf     = '0;
        model_acc     = '0;
        run_reset();
        run_load();
        run_accum();
        run_term();
        run_random();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
                 tests_done, tests_failed, check_total, err_total, dut_i.chk_i.assert_fails);
        if (err_total == 0 && tests_failed == 0 && dut_i.chk_i.assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verif/nfu2_chk.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu2_chk
    import nfu_types_pkg::*;
    import nfu_ctrl_pkg::*;
(
    input logic       clk,
    input logic       i_rst_n,
    input nfu_ctrl_t  i_ctrl,
    input nfu_lanes_t o_output,
    input nfu_tag_t   o_tag
);

    // Count of failed assertions
    int unsigned assert_fails = 0;

    // Outputs stay known once out of reset
    property p_outputs_known;
        @(posedge clk) i_rst_n |-> !$isunknown({o_output, o_tag});
    endproperty

    // Tag leaves two cycles after it entered
    // Needs two clean cycles of history out of reset
    property p_tag_aligned;
        @(posedge clk) (i_rst_n && $past(i_rst_n) && $past(i_rst_n, 2))
            |-> (o_tag == $past(i_ctrl.tag, 2));
    endproperty

    // Accumulators held clear by reset
    property p_reset_clears;
        @(posedge clk) !i_rst_n |-> (o_output == '0);
    endproperty

    a_outputs_known: assert property (p_outputs_known)
        else begin
            $error("o_output or o_tag is unknown while out of reset");
            assert_fails++;
        end

    a_tag_aligned: assert property (p_tag_aligned)
        else begin
            $error("o_tag does not match the tag applied two cycles earlier");
            assert_fails++;
        end

    a_reset_clears: assert property (p_reset_clears)
        else begin
            $error("o_output is not zero while reset is asserted");
            assert_fails++;
        end

endmodule

/* hdl/nfu2_top.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu2_top
    import nfu_types_pkg::*;
    import nfu_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  nfu_products_t i_products,
    input  nfu_lanes_t    i_partial_sum,
    input  nfu_ctrl_t     i_ctrl,
    output nfu_lanes_t    o_output,
    output nfu_tag_t      o_tag
);

    // Registered inputs
    nfu_products_t prod_q;
    nfu_lanes_t    psum_q;
    nfu_ctrl_t     ctrl_q;

    // Buffered extra term per lane
    nfu_lanes_t    term;

    nfu_input_stage input_stage_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_products    (i_products),
        .i_partial_sum (i_partial_sum),
        .i_ctrl        (i_ctrl),
        .o_products    (prod_q),
        .o_partial_sum (psum_q),
        .o_ctrl        (ctrl_q)
    );

    nfu_select_buffer select_buffer_i (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_products(prod_q),
        .i_sel     (ctrl_q.sel),
        .i_wr_addr (ctrl_q.wr_addr),
        .i_rd_addr (ctrl_q.rd_addr),
        .i_wr_en   (ctrl_q.wr_en),
        .o_term    (term)
    );

    // Load and tag come straight from the registered control
    nfu_accum_tree accum_tree_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_products    (prod_q),
        .i_term        (term),
        .i_partial_sum (psum_q),
        .i_load        (ctrl_q.load),
        .i_tag         (ctrl_q.tag),
        .o_sum         (o_output),
        .o_tag         (o_tag)
    );

endmodule

/* hdl/nfu_accum_tree.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu_accum_tree
    import nfu_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  nfu_products_t        i_products,
    input  nfu_lanes_t           i_term,
    input  nfu_lanes_t           i_partial_sum,
    input  logic                 i_load,
    input  logic [`NFU_TAG-1:0]  i_tag,
    output nfu_lanes_t           o_sum,
    output logic [`NFU_TAG-1:0]  o_tag
);

    localparam int PAIRS = `NFU_TN / 2;

    // First tree level, adjacent products added in pairs
    nfu_word_t [`NFU_TN-1:0][PAIRS-1:0] pair_sum;

    // Second tree level, full row sum per lane
    nfu_word_t [`NFU_TN-1:0] row_sum;

    // Value the lane builds on this cycle
    nfu_word_t [`NFU_TN-1:0] base;

    // Next accumulator value
    nfu_word_t [`NFU_TN-1:0] lane_sum;

    nfu_lanes_t           acc_q;
    logic [`NFU_TAG-1:0]  tag_q;

    always_comb begin
        for (int l = 0; l < `NFU_TN; l++) begin
            for (int p = 0; p < PAIRS; p++) begin
                pair_sum[l][p] = i_products.row[l][2*p] + i_products.row[l][2*p+1];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < `NFU_TN; l++) begin
            row_sum[l] = '0;
            for (int p = 0; p < PAIRS; p++) begin
                row_sum[l] = row_sum[l] + pair_sum[l][p];
            end
        end
    end

    // Load restarts from the partial sum, otherwise keep accumulating
    always_comb begin
        for (int l = 0; l < `NFU_TN; l++) begin
            base[l]     = i_load ? i_partial_sum.lane[l] : acc_q.lane[l];
            // All adds wrap at the word width
            lane_sum[l] = row_sum[l] + i_term.lane[l] + base[l];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else begin
            for (int l = 0; l < `NFU_TN; l++) begin
                acc_q.lane[l] <= lane_sum[l];
            end
        end
    end

    // Tag follows the data through the same single stage
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= i_tag;
        end
    end

    assign o_sum = acc_q;
    assign o_tag = tag_q;

endmodule

/* hdl/nfu_select_buffer.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu_select_buffer
    import nfu_types_pkg::*;
    import nfu_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  nfu_products_t             i_products,
    input  nfu_sel_t  [`NFU_TN-1:0]   i_sel,
    input  nfu_addr_t [`NFU_TN-1:0]   i_wr_addr,
    input  nfu_addr_t [`NFU_TN-1:0]   i_rd_addr,
    input  logic      [`NFU_TN-1:0]   i_wr_en,
    output nfu_lanes_t                o_term
);

    // Grid as one list so a select value indexes it directly
    nfu_grid_flat_t grid_flat;

    // Product picked by each lane's select line
    nfu_word_t [`NFU_TN-1:0] picked;

    // Term buffers, one small bank per lane
    nfu_word_t [`NFU_TN-1:0][`NFU_DEPTH-1:0] buf_q;

    assign grid_flat = i_products;

    // Sparse selection, any lane may take any product
    always_comb begin
        for (int l = 0; l < `NFU_TN; l++) begin
            picked[l] = grid_flat[i_sel[l]];
        end
    end

    // Buffer write lands on the edge after the control is seen
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            buf_q <= '0;
        end else begin
            for (int l = 0; l < `NFU_TN; l++) begin
                if (i_wr_en[l]) begin
                    buf_q[l][i_wr_addr[l]] <= picked[l];
                end
            end
        end
    end

    // Read is combinational
    // A write to the same entry this cycle is not visible yet, so the old value comes out
    always_comb begin
        for (int l = 0; l < `NFU_TN; l++) begin
            o_term.lane[l] = buf_q[l][i_rd_addr[l]];
        end
    end

endmodule

/* hdl/nfu_input_stage.sv */
`timescale 1ns/1ns
`include "nfu_macros.svh"

module nfu_input_stage
    import nfu_types_pkg::*;
    import nfu_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  nfu_products_t i_products,
    input  nfu_lanes_t    i_partial_sum,
    input  nfu_ctrl_t     i_ctrl,
    output nfu_products_t o_products,
    output nfu_lanes_t    o_partial_sum,
    output nfu_ctrl_t     o_ctrl
);

    nfu_products_t prod_q;
    nfu_lanes_t    psum_q;
    nfu_ctrl_t     ctrl_q;

    // Products and partial sum, so the adder tree starts from flops
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prod_q <= '0;
            psum_q <= '0;
        end else begin
            prod_q <= i_products;
            psum_q <= i_partial_sum;
        end
    end

    // Control bundle moves in step with its data
    // After reset wr_en and load are inactive
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= i_ctrl;
        end
    end

    assign o_products    = prod_q;
    assign o_partial_sum = psum_q;
    assign o_ctrl        = ctrl_q;

endmodule

/* hdl/nfu_ctrl_pkg.sv */
`include "nfu_macros.svh"

package nfu_ctrl_pkg;

    // Picks one product out of the grid
    typedef logic [`NFU_SEL-1:0] nfu_sel_t;

    // Term buffer entry address
    typedef logic [`NFU_ADDR-1:0] nfu_addr_t;

    // Side tag
    typedef logic [`NFU_TAG-1:0] nfu_tag_t;

    // Control for one item, arrives with its products each cycle
    typedef struct packed {
        // Per lane product select for the buffer write
        nfu_sel_t [`NFU_TN-1:0] sel;
        // Per lane buffer addresses
        nfu_addr_t [`NFU_TN-1:0] wr_addr;
        nfu_addr_t [`NFU_TN-1:0] rd_addr;
        // Per lane buffer write strobe
        logic [`NFU_TN-1:0] wr_en;
        // Start from the partial sum instead of the running sum
        logic load;
        nfu_tag_t tag;
    } nfu_ctrl_t;

endpackage

/* hdl/nfu_types_pkg.sv */
`include "nfu_macros.svh"

package nfu_types_pkg;

    // Number of products handed over by stage one
    localparam int NFU_GRID = `NFU_TN * `NFU_TN;

    // One data word
    typedef logic [`NFU_WIDTH-1:0] nfu_word_t;

    // One word per output lane
    typedef struct packed {
        nfu_word_t [`NFU_TN-1:0] lane;
    } nfu_lanes_t;

    // Product grid, row r feeds lane r
    // Flat product index is row * NFU_TN + column
    typedef struct packed {
        nfu_word_t [`NFU_TN-1:0][`NFU_TN-1:0] row;
    } nfu_products_t;

    // Same grid seen as a flat list of products
    typedef nfu_word_t [NFU_GRID-1:0] nfu_grid_flat_t;

endpackage

/* hdl/nfu_macros.svh */
`ifndef NFU_MACROS_SVH
`define NFU_MACROS_SVH

// Output lanes, also the number of products in each lane's row
`define NFU_TN 4

// Data word width, sums wrap at this width
`define NFU_WIDTH 16

// Term buffer address width per lane
`define NFU_ADDR 2

// Entries in each lane's term buffer
`define NFU_DEPTH (1 << `NFU_ADDR)

// Product select width, covers the whole Tn x Tn grid
`define NFU_SEL 4

// Side tag carried next to the data
`define NFU_TAG 2

`endif
